// ==== source/float_pkg.sv ====
package float_pkg;

    // Single-precision word layout, sign in the top bit.
    localparam int float_width = 32;

    // Biased exponent field, just below the sign.
    localparam int exp_width = 8;

    // Stored fraction field without the hidden one.
    localparam int frac_width = 23;

    // Exponent bias of the format.
    localparam int exp_bias = 127;

    // An all-ones exponent marks infinity or NaN.
    localparam logic [exp_width-1:0] exp_max = 8'hff;

    // Aligned mantissa is the hidden one, the fraction and two guard bits.
    // The adder result is one bit wider than this to hold the carry out.
    localparam int align_width = 26;

endpackage

// ==== source/fpu_op_pkg.sv ====
package fpu_op_pkg;

    // Opcodes of the execution unit. The first two go to the adder.
    typedef enum logic [2:0] {
        op_fadd   = 3'd0,
        op_fsub   = 3'd1,
        op_fsgnj  = 3'd2,
        op_fsgnjn = 3'd3,
        op_fsgnjx = 3'd4,
        op_feq    = 3'd5,
        op_flt    = 3'd6,
        op_fle    = 3'd7
    } fpu_op_e;

    // Cycles from the issue edge to the output registers, the same for every opcode.
    localparam int fpu_latency = 3;

    // Number of sticky exception flags.
    localparam int flag_width = 2;

    // A result was forced to zero or infinity while its fraction was nonzero.
    localparam int flag_ovf = 0;

    // A result passed an infinite or NaN operand through.
    localparam int flag_special = 1;

endpackage

// ==== source/fpu_result_if.sv ====
// One result per cycle at most, no handshake back to the pipeline.
interface fpu_result_if;

    logic                             valid;   // One-cycle strobe per result.
    logic [float_pkg::float_width-1:0] y;
    logic                             ovf;     // Result was forced out of range.
    logic                             special; // Infinite or NaN operand involved.

    // Driven by an execution pipeline.
    modport source (
        output valid,
        output y,
        output ovf,
        output special
    );

    // Read by the retire block.
    modport sink (
        input valid,
        input y,
        input ovf,
        input special
    );

endinterface

// ==== source/fadd_pipe.sv ====
module fadd_pipe (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              in_valid,
    input  fpu_op_pkg::fpu_op_e               op,
    input  logic [float_pkg::float_width-1:0] x1,
    input  logic [float_pkg::float_width-1:0] x2,
    fpu_result_if.source                      res
);

    logic                              accept;
    logic [float_pkg::float_width-1:0] x2n;
    logic                              swap;
    logic [float_pkg::float_width-1:0] lx;
    logic [float_pkg::float_width-1:0] sx;
    logic [float_pkg::exp_width-1:0]   lx_e;
    logic [float_pkg::exp_width-1:0]   sx_e;
    logic [float_pkg::exp_width-1:0]   shift;
    logic [float_pkg::frac_width:0]    sm;
    logic [float_pkg::align_width-1:0] lf;
    logic [float_pkg::align_width-1:0] sf;

    logic                              v0;
    logic [float_pkg::float_width-1:0] lx0;
    logic                              eff_sub0;
    logic [float_pkg::align_width-1:0] lf0;
    logic [float_pkg::align_width-1:0] sf0;

    logic [float_pkg::align_width:0]   sum;
    logic [4:0]                        top;
    logic [float_pkg::align_width:0]   norm;

    logic                              v1;
    logic [float_pkg::float_width-1:0] lx1;
    logic [float_pkg::frac_width:0]    man1;
    logic                              rnd1;
    logic [4:0]                        top1;
    logic                              zero1;

    logic [float_pkg::exp_width-1:0]   lx1_e;
    logic [float_pkg::frac_width+1:0]  rman;
    logic [4:0]                        ttop;
    logic [float_pkg::exp_width:0]     ae;
    logic [float_pkg::exp_width-1:0]   ye;
    logic [float_pkg::frac_width-1:0]  yf;
    logic                              edge_exp;
    logic                              pass;
    logic [float_pkg::float_width-1:0] y_next;
    logic                              ovf_next;

    assign accept = in_valid && (op == fpu_op_pkg::op_fadd || op == fpu_op_pkg::op_fsub);

    // Stage 0. A subtraction is an addition with the sign of x2 flipped.
    assign x2n = (op == fpu_op_pkg::op_fsub) ?
                 {~x2[float_pkg::float_width-1], x2[float_pkg::float_width-2:0]} : x2;

    // Magnitude order on the packed bits, which also orders infinity and NaN on top.
    assign swap = x1[float_pkg::float_width-2:0] < x2n[float_pkg::float_width-2:0];
    assign lx   = swap ? x2n : x1;
    assign sx   = swap ? x1 : x2n;

    assign lx_e  = lx[float_pkg::float_width-2 -: float_pkg::exp_width];
    assign sx_e  = sx[float_pkg::float_width-2 -: float_pkg::exp_width];
    assign shift = lx_e - sx_e;

    // Subnormal operands are flushed to zero here.
    assign lf = (lx_e == '0) ? '0 : {1'b1, lx[float_pkg::frac_width-1:0], 2'b00};
    assign sm = (sx_e == '0) ? '0 : {1'b1, sx[float_pkg::frac_width-1:0]};
    assign sf = {sm, 2'b00} >> shift; // Bits shifted past the guard bits are dropped.

    // Stage 1. Effective subtraction when the signs differ.
    assign sum = eff_sub0 ? {1'b0, lf0} - {1'b0, sf0} : {1'b0, lf0} + {1'b0, sf0};

    always_comb begin
        top = '0;
        for (int i = 0; i <= float_pkg::align_width; i++) begin
            if (sum[i]) begin
                top = 5'(i); // The highest set bit wins.
            end
        end
    end

    // Moves the leading one to the top bit of the sum width.
    assign norm = sum << (5'(float_pkg::align_width) - top);

    // Stage 2. Round half up on the single round bit.
    assign lx1_e = lx1[float_pkg::float_width-2 -: float_pkg::exp_width];
    assign rman  = {1'b0, man1} + {{(float_pkg::frac_width+1){1'b0}}, rnd1};
    assign ttop  = top1 + {4'b0, rman[float_pkg::frac_width+1]}; // Rounding carried out.

    // Bit 25 of the aligned sum has the weight of the larger exponent.
    assign ae = {1'b0, lx1_e} + {4'b0, ttop} - 9'(float_pkg::align_width - 1);

    always_comb begin
        if (ae[float_pkg::exp_width]) begin
            // Wrapped below zero is an underflow, past the top is an overflow.
            ye = (ttop >= 5'(float_pkg::align_width - 1)) ? float_pkg::exp_max : '0;
        end else begin
            ye = ae[float_pkg::exp_width-1:0];
        end
    end

    assign edge_exp = (ye == '0) || (ye == float_pkg::exp_max);
    assign yf       = edge_exp ? '0 : rman[float_pkg::frac_width-1:0];
    assign pass     = (lx1_e == float_pkg::exp_max); // Infinity or NaN on the larger side.

    // Exact cancellation always gives positive zero.
    assign y_next   = pass  ? lx1 :
                      zero1 ? '0 : {lx1[float_pkg::float_width-1], ye, yf};
    assign ovf_next = !pass && !zero1 && edge_exp && (|rman[float_pkg::frac_width-1:0]);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            v0        <= 1'b0;
            v1        <= 1'b0;
            res.valid <= 1'b0;
        end else begin
            v0        <= accept;
            v1        <= v0;
            res.valid <= v1;
        end
    end

    always_ff @(posedge clk) begin
        lx0         <= lx;
        eff_sub0    <= lx[float_pkg::float_width-1] ^ sx[float_pkg::float_width-1];
        lf0         <= lf;
        sf0         <= sf;
        lx1         <= lx0;
        man1        <= norm[float_pkg::align_width -: float_pkg::frac_width+1];
        rnd1        <= norm[float_pkg::align_width-float_pkg::frac_width-1];
        top1        <= top;
        zero1       <= (sum == '0);
        res.y       <= y_next;
        res.ovf     <= ovf_next;
        res.special <= pass;
    end

    // Every result leaving the adder was issued as an add or subtract three edges before.
    accepted_add_op: assert property (@(posedge clk) disable iff (!rstn)
        res.valid |-> $past(in_valid && (op == fpu_op_pkg::op_fadd ||
                                         op == fpu_op_pkg::op_fsub), fpu_op_pkg::fpu_latency));

endmodule

// ==== source/fsgn_cmp_pipe.sv ====
module fsgn_cmp_pipe (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              in_valid,
    input  fpu_op_pkg::fpu_op_e               op,
    input  logic [float_pkg::float_width-1:0] x1,
    input  logic [float_pkg::float_width-1:0] x2,
    fpu_result_if.source                      res
);

    logic                              accept;
    logic                              s1;
    logic                              s2;
    logic                              zero1;
    logic                              zero2;
    logic                              nan1;
    logic                              nan2;
    logic                              any_nan;
    logic                              both_zero;
    logic [float_pkg::float_width-2:0] mag1;
    logic [float_pkg::float_width-2:0] mag2;
    logic                              eq;
    logic                              lt;
    logic [float_pkg::float_width-1:0] y_c;
    logic                              sp_c;

    logic                              v0;
    logic                              v1;
    logic [float_pkg::float_width-1:0] y0;
    logic [float_pkg::float_width-1:0] y1;
    logic                              sp0;
    logic                              sp1;

    // Everything except add and subtract belongs to this pipeline.
    assign accept = in_valid && !(op == fpu_op_pkg::op_fadd || op == fpu_op_pkg::op_fsub);

    assign s1    = x1[float_pkg::float_width-1];
    assign s2    = x2[float_pkg::float_width-1];
    assign zero1 = (x1[float_pkg::float_width-2 -: float_pkg::exp_width] == '0);
    assign zero2 = (x2[float_pkg::float_width-2 -: float_pkg::exp_width] == '0);
    assign nan1  = (x1[float_pkg::float_width-2 -: float_pkg::exp_width] == float_pkg::exp_max)
                   && (|x1[float_pkg::frac_width-1:0]);
    assign nan2  = (x2[float_pkg::float_width-2 -: float_pkg::exp_width] == float_pkg::exp_max)
                   && (|x2[float_pkg::frac_width-1:0]);

    assign any_nan   = nan1 || nan2;
    assign both_zero = zero1 && zero2; // Covers +0 against -0 and flushed subnormals.
    assign mag1      = zero1 ? '0 : x1[float_pkg::float_width-2:0];
    assign mag2      = zero2 ? '0 : x2[float_pkg::float_width-2:0];

    assign eq = !any_nan && (both_zero || (s1 == s2 && mag1 == mag2));

    // With differing signs the negative one is smaller, otherwise compare magnitudes.
    assign lt = !any_nan && !both_zero &&
                ((s1 != s2) ? s1 : (s1 ? (mag1 > mag2) : (mag1 < mag2)));

    always_comb begin
        y_c  = '0;
        sp_c = 1'b0;
        case (op)
            fpu_op_pkg::op_fsgnj:  y_c = {s2, x1[float_pkg::float_width-2:0]};
            fpu_op_pkg::op_fsgnjn: y_c = {~s2, x1[float_pkg::float_width-2:0]};
            fpu_op_pkg::op_fsgnjx: y_c = {s1 ^ s2, x1[float_pkg::float_width-2:0]};
            fpu_op_pkg::op_feq: begin
                y_c[0] = eq;
                sp_c   = any_nan;
            end
            fpu_op_pkg::op_flt: begin
                y_c[0] = lt;
                sp_c   = any_nan;
            end
            fpu_op_pkg::op_fle: begin
                y_c[0] = lt || eq;
                sp_c   = any_nan;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            v0        <= 1'b0;
            v1        <= 1'b0;
            res.valid <= 1'b0;
        end else begin
            v0        <= accept;
            v1        <= v0;
            res.valid <= v1;
        end
    end

    // Two delay stages keep the depth equal to the adder.
    always_ff @(posedge clk) begin
        y0          <= y_c;
        sp0         <= sp_c;
        y1          <= y0;
        sp1         <= sp0;
        res.y       <= y1;
        res.special <= sp1;
    end

    assign res.ovf = 1'b0; // Nothing here is ever forced out of range.

endmodule

// ==== source/fpu_retire.sv ====
module fpu_retire (
    input  logic                              clk,
    input  logic                              rstn,
    fpu_result_if.sink                        add_res,
    fpu_result_if.sink                        cmp_res,
    input  logic                              flag_clr,
    input  logic                              mask_wr,
    input  logic [fpu_op_pkg::flag_width-1:0] mask_data,
    output logic                              out_valid,
    output logic [float_pkg::float_width-1:0] y,
    output logic                              ovf,
    output logic [fpu_op_pkg::flag_width-1:0] flags,
    output logic                              irq
);

    logic                              any_valid;
    logic [float_pkg::float_width-1:0] y_sel;
    logic                              ovf_sel;
    logic                              special_sel;
    logic [fpu_op_pkg::flag_width-1:0] new_flags;
    logic [fpu_op_pkg::flag_width-1:0] mask_q;

    // Both pipelines have the same depth, so at most one side is valid.
    assign any_valid   = add_res.valid || cmp_res.valid;
    assign y_sel       = add_res.valid ? add_res.y : cmp_res.y;
    assign ovf_sel     = add_res.valid ? add_res.ovf : cmp_res.ovf;
    assign special_sel = add_res.valid ? add_res.special : cmp_res.special;

    always_comb begin
        new_flags                          = '0;
        new_flags[fpu_op_pkg::flag_ovf]     = any_valid && ovf_sel;
        new_flags[fpu_op_pkg::flag_special] = any_valid && special_sel;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            ovf       <= 1'b0;
            flags     <= '0;
            mask_q    <= '0;
        end else begin
            out_valid <= any_valid;
            ovf       <= new_flags[fpu_op_pkg::flag_ovf];
            flags     <= (flag_clr ? '0 : flags) | new_flags; // A new flag beats the clear.
            if (mask_wr) begin
                mask_q <= mask_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        y <= any_valid ? y_sel : '0; // Zero between results.
    end

    assign irq = |(flags & mask_q);

    single_source: assert property (@(posedge clk) disable iff (!rstn)
        !(add_res.valid && cmp_res.valid));

endmodule

// ==== source/fpu_top.sv ====
module fpu_top (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              in_valid,
    input  fpu_op_pkg::fpu_op_e               op,
    input  logic [float_pkg::float_width-1:0] x1,
    input  logic [float_pkg::float_width-1:0] x2,
    input  logic                              flag_clr,
    input  logic                              mask_wr,
    input  logic [fpu_op_pkg::flag_width-1:0] mask_data,
    output logic                              out_valid,
    output logic [float_pkg::float_width-1:0] y,
    output logic                              ovf,
    output logic [fpu_op_pkg::flag_width-1:0] flags,
    output logic                              irq
);

    // One result bundle per execution pipeline.
    fpu_result_if add_res ();
    fpu_result_if cmp_res ();

    // Both pipelines see every issue and each picks its own opcodes.
    fadd_pipe fadd_pipe_inst (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .op       (op),
        .x1       (x1),
        .x2       (x2),
        .res      (add_res.source)
    );

    fsgn_cmp_pipe fsgn_cmp_pipe_inst (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .op       (op),
        .x1       (x1),
        .x2       (x2),
        .res      (cmp_res.source)
    );

    fpu_retire fpu_retire_inst (
        .clk       (clk),
        .rstn      (rstn),
        .add_res   (add_res.sink),
        .cmp_res   (cmp_res.sink),
        .flag_clr  (flag_clr),
        .mask_wr   (mask_wr),
        .mask_data (mask_data),
        .out_valid (out_valid),
        .y         (y),
        .ovf       (ovf),
        .flags     (flags),
        .irq       (irq)
    );

endmodule

// ==== dv/fpu_checker.sv ====
module fpu_checker (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              push,
    input  logic [float_pkg::float_width-1:0] exp_y,
    input  logic                              exp_ovf,
    input  logic [fpu_op_pkg::flag_width-1:0] exp_flags,
    input  logic                              exp_irq,
    input  logic                              out_valid,
    input  logic [float_pkg::float_width-1:0] y,
    input  logic                              ovf,
    input  logic [fpu_op_pkg::flag_width-1:0] flags,
    input  logic                              irq,
    output int                                outstanding,
    output int                                errors,
    output int                                tests
);
    timeunit 1ns;
    timeprecision 100ps;

    // Expected results in issue order, oldest at the front.
    logic [float_pkg::float_width-1:0] q_y [$];
    logic                              q_ovf [$];
    logic [fpu_op_pkg::flag_width-1:0] q_flags [$];
    logic                              q_irq [$];
    int                                q_issue [$]; // Cycle of the sampling edge.

    int cycle = 0;
    int idle = 0;
    int pending = 0;
    int err_count = 0;
    int test_count = 0;
    bit reset_checked = 1'b0;
    bit ok;

    assign outstanding = pending;
    assign errors      = err_count;
    assign tests       = test_count;

    task automatic check_field(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] want
    );
        if (got !== want) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, want);
            ok = 1'b0;
        end
    endtask

    // Outputs change on the rising edge, so the falling edge sees them settled.
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (rstn && !reset_checked) begin
            reset_checked = 1'b1;
            ok            = 1'b1;
            test_count++;
            check_field("out_valid", 32'(out_valid), 32'd0);
            check_field("flags", 32'(flags), 32'd0);
            check_field("irq", 32'(irq), 32'd0);
            $display("test reset: %s", ok ? "ok" : "mismatch");
            err_count += ok ? 0 : 1;
        end
        if (rstn && push) begin
            q_y.push_back(exp_y);
            q_ovf.push_back(exp_ovf);
            q_flags.push_back(exp_flags);
            q_irq.push_back(exp_irq);
            q_issue.push_back(cycle + 1); // The DUT samples on the next rising edge.
        end
        if (rstn && out_valid) begin
            idle = 0;
            if (q_y.size() == 0) begin
                $display("Error at %0t: a result arrived with no operation outstanding", $time);
                err_count++;
            end else begin
                ok = 1'b1;
                test_count++;
                check_field("y", y, q_y.pop_front());
                check_field("ovf", 32'(ovf), 32'(q_ovf.pop_front()));
                check_field("flags", 32'(flags), 32'(q_flags.pop_front()));
                check_field("irq", 32'(irq), 32'(q_irq.pop_front()));
                check_field("latency", 32'(cycle - q_issue.pop_front()),
                            32'(fpu_op_pkg::fpu_latency));
                $display("test %0d: %s", test_count, ok ? "ok" : "mismatch");
                err_count += ok ? 0 : 1;
            end
        end else if (q_y.size() != 0) begin
            idle++;
            if (idle >= 20) begin
                $display("Error at %0t: no result for 20 cycles with %0d operations waiting",
                         $time, q_y.size());
                err_count++;
                idle = 0;
                q_y.delete();
                q_ovf.delete();
                q_flags.delete();
                q_irq.delete();
                q_issue.delete();
            end
        end
        pending = q_y.size();
    end

endmodule

// ==== dv/fpu_tb.sv ====
module fpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {ctl_issue, ctl_mask, ctl_clear} ctl_e;

    // One table row. On a mask row the flags field holds the mask data.
    typedef struct packed {
        ctl_e                              ctl;
        fpu_op_pkg::fpu_op_e               op;
        logic [float_pkg::float_width-1:0] x1;
        logic [float_pkg::float_width-1:0] x2;
        logic [float_pkg::float_width-1:0] y;
        logic                              ovf;
        logic [fpu_op_pkg::flag_width-1:0] flags;
        logic                              irq;
    } entry_t;

    logic                              clk;
    logic                              rstn;
    logic                              in_valid;
    fpu_op_pkg::fpu_op_e               op;
    logic [float_pkg::float_width-1:0] x1;
    logic [float_pkg::float_width-1:0] x2;
    logic                              flag_clr;
    logic                              mask_wr;
    logic [fpu_op_pkg::flag_width-1:0] mask_data;
    logic                              out_valid;
    logic [float_pkg::float_width-1:0] y;
    logic                              ovf;
    logic [fpu_op_pkg::flag_width-1:0] flags;
    logic                              irq;
    logic                              push;
    logic [float_pkg::float_width-1:0] exp_y;
    logic                              exp_ovf;
    logic [fpu_op_pkg::flag_width-1:0] exp_flags;
    logic                              exp_irq;
    int                                outstanding;
    int                                errors;
    int                                tests;
    bit                                drained;
    entry_t                            tbl [$];

    fpu_top fpu_top_inst (.*);
    fpu_checker fpu_checker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic op_entry(
        input fpu_op_pkg::fpu_op_e               o,
        input logic [float_pkg::float_width-1:0] a,
        input logic [float_pkg::float_width-1:0] b,
        input logic [float_pkg::float_width-1:0] r,
        input logic                              v,
        input logic [fpu_op_pkg::flag_width-1:0] f,
        input logic                              q
    );
        tbl.push_back(entry_t'{ctl_issue, o, a, b, r, v, f, q});
    endtask

    task automatic ctl_entry(input ctl_e c, input logic [fpu_op_pkg::flag_width-1:0] data);
        tbl.push_back(entry_t'{c, fpu_op_pkg::op_fadd, '0, '0, '0, 1'b0, data, 1'b0});
    endtask

    // Stops issuing, then waits until every result has come back.
    task automatic wait_drain(output bit done);
        int n;
        in_valid <= 1'b0;
        push     <= 1'b0;
        mask_wr  <= 1'b0;
        flag_clr <= 1'b0;
        n = 0;
        @(posedge clk);
        while (outstanding != 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        done = (outstanding == 0);
    endtask

    initial begin
        rstn      = 1'b0;
        in_valid  = 1'b0;
        op        = fpu_op_pkg::op_fadd;
        x1        = '0;
        x2        = '0;
        flag_clr  = 1'b0;
        mask_wr   = 1'b0;
        mask_data = '0;
        push      = 1'b0;
        exp_y     = '0;
        exp_ovf   = 1'b0;
        exp_flags = '0;
        exp_irq   = 1'b0;
        drained   = 1'b1;

        // Add and subtract, then both pipelines mixed back to back.
        op_entry(fpu_op_pkg::op_fsub,   'h40400000, 'h3f800000, 'h40000000, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_fadd,   'h3fc00000, 'h40100000, 'h40700000, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_fadd,   'hc0000000, 'h40000000, 'h00000000, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_fadd,   'hbf800000, 'h40800000, 'h40400000, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_fsub,   'h3f800000, 'h40800000, 'hc0400000, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_fadd,   'h3f000000, 'h3f000000, 'h3f800000, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_fsgnj,  'h3fc00000, 'hc0000000, 'hbfc00000, 1'b0, 2'b00, 1'b0);
        // The largest subnormal next to the smallest normal would change the sum if kept.
        op_entry(fpu_op_pkg::op_fadd,   'h00800000, 'h007fffff, 'h00800000, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_fsgnjn, 'h3fc00000, 'hc0000000, 'h3fc00000, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_fsub,   'h40000000, 'h40000000, 'h00000000, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_fsgnjx, 'hbfc00000, 'hc0000000, 'h3fc00000, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_feq,    'h00000000, 'h80000000, 'h00000001, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_flt,    'h80000000, 'h00000000, 'h00000000, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_fle,    'h80000000, 'h00000000, 'h00000001, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_flt,    'hbf800000, 'h3f800000, 'h00000001, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_fle,    'h40400000, 'h40000000, 'h00000000, 1'b0, 2'b00, 1'b0);
        op_entry(fpu_op_pkg::op_flt,    'hc0400000, 'hc0000000, 'h00000001, 1'b0, 2'b00, 1'b0);
        // NaN compares set the special flag, which then stays set.
        op_entry(fpu_op_pkg::op_feq,    'h7fc00000, 'h3f800000, 'h00000000, 1'b0, 2'b10, 1'b0);
        op_entry(fpu_op_pkg::op_fle,    'h3f800000, 'h7fc00000, 'h00000000, 1'b0, 2'b10, 1'b0);
        op_entry(fpu_op_pkg::op_fadd,   'h3f800000, 'h3f800000, 'h40000000, 1'b0, 2'b10, 1'b0);
        ctl_entry(ctl_mask, 2'b10);
        op_entry(fpu_op_pkg::op_fsgnj,  'h3f800000, 'h00000000, 'h3f800000, 1'b0, 2'b10, 1'b1);
        op_entry(fpu_op_pkg::op_fadd,   'h7f7fffff, 'h7f7fffff, 'h7f800000, 1'b1, 2'b11, 1'b1);
        ctl_entry(ctl_clear, 2'b00);
        op_entry(fpu_op_pkg::op_fadd,   'h3f800000, 'h40000000, 'h40400000, 1'b0, 2'b00, 1'b0);
        ctl_entry(ctl_mask, 2'b01);
        op_entry(fpu_op_pkg::op_fadd,   'h7f7fffff, 'h7f7fffff, 'h7f800000, 1'b1, 2'b01, 1'b1);
        op_entry(fpu_op_pkg::op_flt,    'h3f800000, 'h40000000, 'h00000001, 1'b0, 2'b01, 1'b1);
        ctl_entry(ctl_clear, 2'b00);
        op_entry(fpu_op_pkg::op_feq,    'h40000000, 'h40000000, 'h00000001, 1'b0, 2'b00, 1'b0);
        // An infinite operand alone raises special, which the mask keeps off irq.
        op_entry(fpu_op_pkg::op_fadd,   'h7f800000, 'h3f800000, 'h7f800000, 1'b0, 2'b10, 1'b0);

        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < tbl.size(); i++) begin
            if (tbl[i].ctl != ctl_issue) begin
                wait_drain(drained); // Control writes go in while the unit is idle.
            end
            if (!drained) begin
                break;
            end
            in_valid  <= (tbl[i].ctl == ctl_issue);
            push      <= (tbl[i].ctl == ctl_issue);
            mask_wr   <= (tbl[i].ctl == ctl_mask);
            flag_clr  <= (tbl[i].ctl == ctl_clear);
            mask_data <= tbl[i].flags;
            op        <= tbl[i].op;
            x1        <= tbl[i].x1;
            x2        <= tbl[i].x2;
            exp_y     <= tbl[i].y;
            exp_ovf   <= tbl[i].ovf;
            exp_flags <= tbl[i].flags;
            exp_irq   <= tbl[i].irq;
            @(posedge clk);
        end
        if (drained) begin
            wait_drain(drained);
        end

        if (!drained) begin
            $display("Timeout: results still outstanding after 20 cycles.");
        end
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0 && drained) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== src.f ====
source/float_pkg.sv
source/fpu_op_pkg.sv
source/fpu_result_if.sv
source/fadd_pipe.sv
source/fsgn_cmp_pipe.sv
source/fpu_retire.sv
source/fpu_top.sv
dv/fpu_checker.sv
dv/fpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module fpu_tb -f src.f -o fpu_sim

out="$(./obj_dir/fpu_sim)"
echo "$out"

if echo "$out" | grep -qF -- '*** PASSED ***'; then
    exit 0
fi
exit 1
